// File: cpu86Pkg.sv
`default_nettype none

package cpu86Pkg;

    typedef logic [15:0] word_t;    // Data or address word
    typedef logic [7:0]  byte_t;    // Bus byte
    typedef logic [2:0]  regSel_t;  // AX..DI at word width, AL..BH at byte width
    typedef logic [11:0] flags_t;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        aluAdd,
        aluOr,
        aluAdc,
        aluSbb,
        aluAnd,
        aluSub,
        aluXor,
        aluCmp
    } aluOp_t;

    // Jcc condition, opcode bits 3:1
    typedef enum logic [2:0] {
        condO,
        condC,
        condZ,
        condBe,     // CF or ZF
        condS,
        condP,
        condL,      // SF != OF
        condLe      // ZF or SF != OF
    } cond_t;

    // Flag bit positions, bit 1 always reads 1
    localparam int flagCf = 0;
    localparam int flagPf = 2;
    localparam int flagAf = 4;
    localparam int flagZf = 6;
    localparam int flagSf = 7;
    localparam int flagTf = 8;
    localparam int flagIf = 9;
    localparam int flagDf = 10;
    localparam int flagOf = 11;

    typedef enum logic [1:0] {fetchOp, modrmRd, execute} seqState_t;

    localparam regSel_t regAx = 3'd0;
    localparam regSel_t regCx = 3'd1;
    localparam regSel_t regDx = 3'd2;

endpackage

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
    import cpu86Pkg::*;
(
    input  logic    clk25,
    input  logic    rstN,
    input  regSel_t rdSel,
    input  regSel_t wrSel,
    input  logic    wide,
    input  logic    wrEn,
    input  word_t   wrData,
    output word_t   rdData,
    output word_t   axVal,
    output word_t   cxVal,
    output word_t   dxVal
);

    word_t regs [8];    // AX CX DX BX SP BP SI DI

    // Byte selectors 4..7 reach the high halves of AX..BX
    always_comb begin
        if (wide)
            rdData = regs[rdSel];
        else if (rdSel[2])
            rdData = {8'h00, regs[{1'b0, rdSel[1:0]}][15:8]};
        else
            rdData = {8'h00, regs[rdSel][7:0]};
    end

    always_ff @(posedge clk25) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= 16'h0000;
        end else if (wrEn) begin
            if (wide)
                regs[wrSel] <= wrData;
            else if (wrSel[2])
                regs[{1'b0, wrSel[1:0]}][15:8] <= wrData[7:0];
            else
                regs[wrSel][7:0] <= wrData[7:0];    // Other half untouched
        end
    end

    // Fixed taps for CBW/CWD, LOOP and port I/O
    assign axVal = regs[regAx];
    assign cxVal = regs[regCx];
    assign dxVal = regs[regDx];

endmodule

`default_nettype wire

// File: aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit
    import cpu86Pkg::*;
(
    input  word_t  op1,
    input  word_t  op2,
    input  aluOp_t aluOp,
    input  logic   wide,
    input  flags_t flagsIn,
    input  cond_t  condSel,
    output word_t  result,
    output flags_t flagsOut,
    output logic   condMet
);

    logic [16:0] sum;       // Bit 16 is carry or borrow out at word width
    logic        carryIn;
    logic        isArith;
    logic        isSub;
    logic        msb1;
    logic        msb2;
    logic        msbR;
    logic        zero;
    logic        carry;
    logic        overflow;

    assign carryIn = (aluOp == aluAdc || aluOp == aluSbb) ? flagsIn[flagCf] : 1'b0;
    assign isSub   = (aluOp == aluSub || aluOp == aluSbb || aluOp == aluCmp);
    assign isArith = isSub || aluOp == aluAdd || aluOp == aluAdc;

    always_comb begin
        case (aluOp)
            aluAdd, aluAdc:         sum = {1'b0, op1} + {1'b0, op2} + {16'h0000, carryIn};
            aluSub, aluSbb, aluCmp: sum = {1'b0, op1} - {1'b0, op2} - {16'h0000, carryIn};
            aluOr:                  sum = {1'b0, op1 | op2};
            aluAnd:                 sum = {1'b0, op1 & op2};
            default:                sum = {1'b0, op1 ^ op2};
        endcase
    end

    assign result = sum[15:0];

    // Width select
    assign msb1  = wide ? op1[15] : op1[7];
    assign msb2  = wide ? op2[15] : op2[7];
    assign msbR  = wide ? sum[15] : sum[7];
    assign zero  = wide ? (sum[15:0] == 16'h0000) : (sum[7:0] == 8'h00);
    assign carry = wide ? sum[16] : (op1[8] ^ op2[8] ^ sum[8]);   // Carry into bit 8

    // Add needs equal operand signs, subtract needs different ones
    assign overflow = ((msb1 ^ msb2) == isSub) && (msbR != msb1);

    always_comb begin
        flagsOut         = 12'h002;
        flagsOut[flagCf] = isArith & carry;
        flagsOut[flagPf] = ~^sum[7:0];      // Low byte only
        flagsOut[flagAf] = isArith ? (op1[4] ^ op2[4] ^ sum[4]) : sum[4];
        flagsOut[flagZf] = zero;
        flagsOut[flagSf] = msbR;
        flagsOut[flagTf] = flagsIn[flagTf];
        flagsOut[flagIf] = flagsIn[flagIf];
        flagsOut[flagDf] = flagsIn[flagDf];
        flagsOut[flagOf] = isArith & overflow;
    end

    // --------------------------------------------------------------------
    // Jump condition from the current flags
    // --------------------------------------------------------------------
    always_comb begin
        case (condSel)
            condO:   condMet = flagsIn[flagOf];
            condC:   condMet = flagsIn[flagCf];
            condZ:   condMet = flagsIn[flagZf];
            condBe:  condMet = flagsIn[flagCf] | flagsIn[flagZf];
            condS:   condMet = flagsIn[flagSf];
            condP:   condMet = flagsIn[flagPf];
            condL:   condMet = flagsIn[flagSf] ^ flagsIn[flagOf];
            default: condMet = (flagsIn[flagSf] ^ flagsIn[flagOf]) | flagsIn[flagZf];
        endcase
    end

endmodule

`default_nettype wire

// File: instrSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module instrSequencer
    import cpu86Pkg::*;
#(
    parameter word_t resetIp = 16'hFFF0
) (
    input  logic    clk25,
    input  logic    rstN,
    input  byte_t   dataIn,
    input  word_t   rdData,
    input  word_t   axVal,
    input  word_t   cxVal,
    input  word_t   dxVal,
    input  word_t   result,
    input  flags_t  flagsOut,
    input  logic    condMet,
    input  word_t   portIn,
    output word_t   addr,
    output regSel_t rdSel,
    output regSel_t wrSel,
    output logic    wide,
    output logic    wrEn,
    output word_t   wrData,
    output word_t   op1,
    output word_t   op2,
    output aluOp_t  aluOp,
    output cond_t   condSel,
    output flags_t  flagsIn,
    output word_t   portAddr,
    output word_t   portOut,
    output logic    portWide,
    output logic    portClk
);

    seqState_t  state;
    word_t      ip;
    byte_t      opcode;
    logic [5:0] modrm;      // Reg and rm fields, mod is treated as 11
    logic [1:0] micro;      // Step inside modrmRd or execute
    flags_t     flags;

    word_t ipNext;
    word_t byteSext;        // Sign-extended byte from the bus
    logic  toReg;           // Reg field is the destination
    logic  loopTaken;

    assign addr     = ip;   // No data accesses, bus always shows IP
    assign flagsIn  = flags;
    assign ipNext   = ip + 16'd1;
    assign byteSext = {{8{dataIn[7]}}, dataIn};
    assign toReg    = opcode[1] && (opcode[7:2] != 6'b100000);

    // JCXZ tests CX as is, the LOOP forms test it after the decrement
    assign loopTaken = (opcode[1:0] == 2'b11) ? (cxVal == 16'h0000)
                     : (cxVal != 16'h0001) && (opcode[1] || (opcode[0] == flags[flagZf]));

    always_ff @(posedge clk25) begin
        if (!rstN) begin
            state    <= fetchOp;
            ip       <= resetIp;
            micro    <= 2'd0;
            flags    <= 12'h002;
            wrEn     <= 1'b0;
            portClk  <= 1'b0;
            portWide <= 1'b0;
            portAddr <= 16'h0000;
            portOut  <= 16'h0000;
        end else begin
            wrEn    <= 1'b0;    // One-cycle strobes
            portClk <= 1'b0;
            case (state)
                // ------------------------------------------------------------
                // Opcode decode
                // ------------------------------------------------------------
                fetchOp: begin
                    opcode <= dataIn;
                    ip     <= ipNext;
                    micro  <= 2'd0;
                    casez (dataIn)
                        8'b00??_?0??: begin             // ALU r/m, reg
                            aluOp <= aluOp_t'(dataIn[5:3]);
                            wide  <= dataIn[0];
                            state <= modrmRd;
                        end
                        8'b00??_?10?: begin             // ALU AL/AX, imm
                            aluOp <= aluOp_t'(dataIn[5:3]);
                            wide  <= dataIn[0];
                            rdSel <= regAx;
                            wrSel <= regAx;
                            state <= execute;
                        end
                        8'b1000_00??, 8'b1000_10??: begin
                            wide  <= dataIn[0];
                            state <= modrmRd;
                        end
                        8'b1011_????: begin             // MOV reg, imm
                            wide  <= dataIn[3];
                            wrSel <= dataIn[2:0];
                            state <= execute;
                        end
                        8'b0100_????: begin             // INC/DEC r16
                            wide  <= 1'b1;
                            rdSel <= dataIn[2:0];
                            wrSel <= dataIn[2:0];
                            aluOp <= dataIn[3] ? aluSub : aluAdd;
                            state <= execute;
                        end
                        8'b1001_0???: begin             // XCHG AX, r16
                            wide  <= 1'b1;
                            rdSel <= dataIn[2:0];
                            state <= execute;
                        end
                        8'b1001_100?, 8'b1110_00??: begin
                            wide  <= 1'b1;
                            state <= execute;
                        end
                        8'b0111_????: begin
                            condSel <= cond_t'(dataIn[3:1]);
                            state   <= execute;
                        end
                        8'b1110_10?1: state <= execute;   // JMP rel16/rel8
                        8'b1110_?1??: begin             // IN/OUT
                            wide  <= dataIn[0];
                            state <= execute;
                        end
                        8'hF5:        flags[flagCf] <= ~flags[flagCf];
                        8'b1111_100?: flags[flagCf] <= dataIn[0];
                        8'b1111_101?: flags[flagIf] <= dataIn[0];
                        8'b1111_110?: flags[flagDf] <= dataIn[0];
                        default:      state <= fetchOp;   // Treated as NOP
                    endcase
                end

                // ModRM byte, then reg operand, then rm operand
                modrmRd: begin
                    case (micro)
                        2'd0: begin
                            modrm <= dataIn[5:0];
                            ip    <= ipNext;
                            rdSel <= dataIn[5:3];
                            micro <= 2'd1;
                            if (opcode[7])
                                aluOp <= aluOp_t'(dataIn[5:3]);   // Group op
                        end
                        2'd1: begin
                            if (toReg)
                                op1 <= rdData;
                            else
                                op2 <= rdData;
                            rdSel <= modrm[2:0];
                            micro <= 2'd2;
                        end
                        default: begin
                            if (toReg)
                                op2 <= rdData;
                            else
                                op1 <= rdData;
                            wrSel <= toReg ? modrm[5:3] : modrm[2:0];
                            micro <= opcode[7] ? 2'd0 : 2'd2;   // Register ALU skips imm
                            state <= execute;
                        end
                    endcase
                end

                // ------------------------------------------------------------
                // Per-opcode execute steps
                // ------------------------------------------------------------
                execute: begin
                    casez (opcode)
                        8'b00??_?0??, 8'b00??_?10?, 8'b1000_00??: begin
                            case (micro)
                                2'd0: begin
                                    if (!opcode[7])
                                        op1 <= rdData;          // AL or AX
                                    if (opcode[1:0] == 2'b11)
                                        op2 <= byteSext;        // Opcode 83
                                    else
                                        op2 <= {8'h00, dataIn};
                                    ip    <= ipNext;
                                    micro <= (opcode[1:0] == 2'b01) ? 2'd1 : 2'd2;
                                end
                                2'd1: begin
                                    op2[15:8] <= dataIn;
                                    ip        <= ipNext;
                                    micro     <= 2'd2;
                                end
                                default: begin
                                    wrData <= result;
                                    wrEn   <= (aluOp != aluCmp);
                                    flags  <= flagsOut;
                                    state  <= fetchOp;
                                end
                            endcase
                        end
                        8'b1000_10??: begin             // MOV r/m
                            wrData <= op2;
                            wrEn   <= 1'b1;
                            state  <= fetchOp;
                        end
                        8'b1011_????: begin
                            ip <= ipNext;
                            if (micro == 2'd0)
                                wrData <= {8'h00, dataIn};
                            else
                                wrData[15:8] <= dataIn;
                            if (wide && micro == 2'd0) begin
                                micro <= 2'd1;
                            end else begin
                                wrEn  <= 1'b1;
                                state <= fetchOp;
                            end
                        end
                        8'b0100_????: begin
                            if (micro == 2'd0) begin
                                op1   <= rdData;
                                op2   <= 16'h0001;
                                micro <= 2'd1;
                            end else begin
                                wrData <= result;
                                wrEn   <= 1'b1;
                                flags  <= {flagsOut[11:1], flags[flagCf]};  // CF kept
                                state  <= fetchOp;
                            end
                        end
                        8'b1001_0???: begin
                            wrEn <= 1'b1;
                            if (micro == 2'd0) begin
                                op1    <= axVal;        // Old AX for the second write
                                wrSel  <= regAx;
                                wrData <= rdData;
                                micro  <= 2'd1;
                            end else begin
                                wrSel  <= opcode[2:0];
                                wrData <= op1;
                                state  <= fetchOp;
                            end
                        end
                        8'b1001_100?: begin             // CBW, CWD
                            wrSel  <= opcode[0] ? regDx : regAx;
                            wrData <= opcode[0] ? {16{axVal[15]}} : {{8{axVal[7]}}, axVal[7:0]};
                            wrEn   <= 1'b1;
                            state  <= fetchOp;
                        end
                        8'b0111_????: begin
                            ip    <= (condMet ^ opcode[0]) ? ipNext + byteSext : ipNext;
                            state <= fetchOp;
                        end
                        8'b1110_00??: begin             // LOOPNZ LOOPZ LOOP JCXZ
                            ip <= loopTaken ? ipNext + byteSext : ipNext;
                            if (opcode[1:0] != 2'b11) begin
                                wrSel  <= regCx;
                                wrData <= cxVal - 16'd1;
                                wrEn   <= 1'b1;
                            end
                            state <= fetchOp;
                        end
                        8'b1110_10?1: begin
                            if (opcode[1]) begin
                                ip    <= ipNext + byteSext;
                                state <= fetchOp;
                            end else if (micro == 2'd0) begin
                                op1[7:0] <= dataIn;
                                ip       <= ipNext;
                                micro    <= 2'd1;
                            end else begin
                                ip    <= ipNext + {dataIn, op1[7:0]};
                                state <= fetchOp;
                            end
                        end
                        8'b1110_?1??: begin
                            if (micro == 2'd0) begin
                                if (opcode[3]) begin
                                    portAddr <= dxVal;
                                end else begin
                                    portAddr <= {8'h00, dataIn};
                                    ip       <= ipNext;
                                end
                                portOut  <= axVal;
                                portWide <= opcode[0];
                                micro    <= 2'd1;
                            end else begin
                                if (opcode[1]) begin
                                    portClk <= 1'b1;
                                end else begin
                                    wrSel  <= regAx;
                                    wrData <= portIn;   // Sampled in the last step
                                    wrEn   <= 1'b1;
                                end
                                state <= fetchOp;
                            end
                        end
                        default: state <= fetchOp;
                    endcase
                end

                default: state <= fetchOp;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cpu86Top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu86Top
    import cpu86Pkg::*;
#(
    parameter word_t resetIp = 16'hFFF0
) (
    input  logic  clk25,
    input  logic  rstN,
    input  byte_t dataIn,
    input  word_t portIn,
    output word_t addr,
    output word_t portAddr,
    output word_t portOut,
    output logic  portWide,
    output logic  portClk
);

    // Register file side
    regSel_t rdSel;
    regSel_t wrSel;
    logic    wide;
    logic    wrEn;
    word_t   wrData;
    word_t   rdData;
    word_t   axVal;
    word_t   cxVal;
    word_t   dxVal;

    // ALU side
    word_t   op1;
    word_t   op2;
    aluOp_t  aluOp;
    cond_t   condSel;
    flags_t  flagsIn;
    word_t   result;
    flags_t  flagsOut;
    logic    condMet;

    regFile i_regFile (
        .clk25(clk25), .rstN(rstN),
        .rdSel(rdSel), .wrSel(wrSel), .wide(wide), .wrEn(wrEn), .wrData(wrData),
        .rdData(rdData), .axVal(axVal), .cxVal(cxVal), .dxVal(dxVal)
    );

    aluUnit i_aluUnit (
        .op1(op1), .op2(op2), .aluOp(aluOp), .wide(wide),
        .flagsIn(flagsIn), .condSel(condSel),
        .result(result), .flagsOut(flagsOut), .condMet(condMet)
    );

    instrSequencer #(
        .resetIp(resetIp)
    ) i_instrSequencer (
        .clk25(clk25), .rstN(rstN), .dataIn(dataIn),
        .rdData(rdData), .axVal(axVal), .cxVal(cxVal), .dxVal(dxVal),
        .result(result), .flagsOut(flagsOut), .condMet(condMet), .portIn(portIn),
        .addr(addr), .rdSel(rdSel), .wrSel(wrSel), .wide(wide), .wrEn(wrEn),
        .wrData(wrData), .op1(op1), .op2(op2), .aluOp(aluOp), .condSel(condSel),
        .flagsIn(flagsIn), .portAddr(portAddr), .portOut(portOut),
        .portWide(portWide), .portClk(portClk)
    );

endmodule

`default_nettype wire

// File: seqProps_chk.sv
`timescale 1ns/1ns
`default_nettype none

module seqProps
    import cpu86Pkg::*;
(
    input logic      clk25,
    input logic      rstN,
    input seqState_t state,
    input logic      portClk,
    input logic      wrEn
);

    // ----------------------------------------------------------------------
    // Port strobe
    // ----------------------------------------------------------------------
    pulseOneCycle: assert property (
        @(posedge clk25) disable iff (!rstN)
        portClk |=> !portClk
    ) else $error("portClk stayed high for two cycles");

    // Strobes cleared by reset
    resetClears: assert property (
        @(posedge clk25)
        !rstN |=> (!portClk && !wrEn)
    ) else $error("portClk or wrEn high after reset");

    // ----------------------------------------------------------------------
    // FSM encoding
    // ----------------------------------------------------------------------
    legalState: assert property (
        @(posedge clk25) disable iff (!rstN)
        state inside {fetchOp, modrmRd, execute}
    ) else $error("Sequencer state outside its encoding");

endmodule

`default_nettype wire

// File: cpu86Tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu86Tb
    import cpu86Pkg::*;
;

    localparam int cyclesPerEvent = 200;
    localparam int tailCycles     = 50;

    logic  clk25;
    logic  rstN;
    byte_t dataIn;
    word_t portIn;
    word_t addr;
    word_t portAddr;
    word_t portOut;
    logic  portWide;
    logic  portClk;

    byte_t mem [65536];     // Program, portIn value and expected events
    word_t expAddr [$];
    word_t expData [$];
    logic  expWide [$];
    bit    loaded;

    cpu86Top #(
        .resetIp(16'hFFF0)
    ) i_cpu86Top (
        .clk25(clk25), .rstN(rstN), .dataIn(dataIn), .portIn(portIn),
        .addr(addr), .portAddr(portAddr), .portOut(portOut),
        .portWide(portWide), .portClk(portClk)
    );

    bind instrSequencer seqProps i_seqProps (
        .clk25(clk25), .rstN(rstN), .state(state), .portClk(portClk), .wrEn(wrEn)
    );

    always #5 clk25 = ~clk25;

    // Memory answers 1 ns after each edge
    always @(posedge clk25) begin
        #1;
        dataIn = mem[addr];
    end

    // ----------------------------------------------------------------------
    // Failure and compare tasks
    // ----------------------------------------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
        if (actVal !== expVal)
            failRun($sformatf("ERROR %s: expected %h, actual %h", name, expVal, actVal));
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal)
            failRun($sformatf("ERROR %s: expected %b, actual %b", name, expVal, actVal));
    endtask

    task automatic loadTests();
        word_t ptr;
        for (int i = 0; i < 65536; i++)
            mem[i] = byte_t'((i >> 8) ^ i);    // Spread over the whole address
        $readmemh("cpu86Tests.hex", mem);
        portIn = {mem[16'h7FFF], mem[16'h7FFE]};
        ptr = 16'h8000;
        while (mem[ptr + 16'd4] != 8'hFF) begin     // Width byte FF is the end marker
            expAddr.push_back({mem[ptr + 16'd1], mem[ptr]});
            expData.push_back({mem[ptr + 16'd3], mem[ptr + 16'd2]});
            expWide.push_back(mem[ptr + 16'd4][0]);
            ptr = ptr + 16'd5;
        end
    endtask

    // Watchdog scaled to the event count
    initial begin
        wait (loaded);
        repeat (expAddr.size() * cyclesPerEvent) @(posedge clk25);
        failRun("Timeout: the expected OUT events did not all arrive in time");
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int  evIdx;
        string name;
        clk25      = 1'b0;
        rstN       = 1'b0;
        dataIn     = 8'h00;
        portIn     = 16'h0000;
        evIdx      = 0;
        loadTests();
        loaded = 1'b1;
        repeat (8) @(posedge clk25);
        #1 rstN = 1'b1;

        while (evIdx < expAddr.size()) begin
            @(negedge clk25);   // Outputs settled mid-cycle
            if (portClk) begin
                name = $sformatf("outEvent%0d", evIdx);
                checkWord(name, expAddr[evIdx], portAddr);
                checkWord(name, expData[evIdx], portOut);
                checkBit(name, expWide[evIdx], portWide);
                evIdx++;
            end
        end

        repeat (tailCycles) begin
            @(negedge clk25);
            if (portClk)
                failRun("An OUT pulse came after the last expected event");
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu86Tests.hex
// Bytes in hex, @ lines set the byte address. Program at 0000, portIn word at 7FFE (lo, hi)
// OUT events at 8000, five bytes each: port lo, port hi, data lo, data hi, width; FF width ends
@0000
B8 34 12 B4 56 B0 78 E7 10 BB CD AB 89 D8 B9 11 11 91 E7 11 8A E1 E7 12
B8 34 12 BB 0F 0F 01 D8 09 D8 F9 11 D8 F9 19 D8 21 D8 33 C1 29 C8 39 C8 E7 20 00 D8 E7 21
B8 34 12 05 11 11 0D 00 F0 F8 15 01 00 F9 1D 46 00 25 F0 FF 35 FF 00
2D 0F 02 3D 00 F0 E7 22 04 25 2C 05 34 0F E7 23
BA 00 01 81 C2 00 02 81 CA 0F 00 F9 81 D2 00 10 F8 83 DA FF 83 E2 F0
83 EA 10 81 F2 FF 00 83 FA 80 80 C2 01 89 D0 E7 24
B8 00 00 B9 05 00
83 F9 05 74 03 0D 01 00 83 F9 05 75 03 0D 02 00 83 F9 06 72 03 0D 04 00
83 F9 06 73 03 0D 08 00 83 F9 06 7C 03 0D 10 00 83 F9 06 7F 03 0D 20 00
83 F9 04 76 03 0D 40 00 83 F9 04 7A 03 0D 80 00 83 F9 04 7B 03 0D 00 01
83 F9 04 78 03 0D 00 02 B9 00 80 83 F9 01 70 03 0D 00 04 83 F9 01 71 03 0D 00 08
83 F9 01 7D 03 0D 00 10 83 F9 01 7E 03 0D 00 20 83 F9 01 79 03 0D 00 40
83 F9 01 77 03 0D 00 80 E7 30
B8 00 00 F8 F5 15 10 00 F9 F5 15 10 00 F9 1D 01 00 FA FB FC FD E7 31
B8 00 00 B9 04 00 40 E2 FD B9 0A 00 40 3D 06 00 E0 FA
B9 03 00 40 39 C0 E1 FB E3 01 40 B9 01 00 E3 01 40 48 E7 40
B8 81 80 E6 41 BA 23 01 EF EE E5 50 EF B8 00 00 E4 51 E7 52
B8 85 00 98 99 EF B8 7F 01 98 99 EF EB FE
@7FFE
3A 9C
@8000
10 00 78 56 01  11 00 11 11 01  12 00 11 CD 01  20 00 F5 F8 01
21 00 04 F8 01  22 00 00 F0 01  23 00 2F F0 01  24 00 00 13 01
30 00 EA 1A 01  31 00 1F 00 01  40 00 09 00 01  41 00 81 80 00
23 01 81 80 01  23 01 81 80 00  23 01 3A 9C 01  52 00 3A 00 01
FF FF 85 FF 01  00 00 7F 00 01  FF FF FF FF FF
@FFF0
E9 0D 00

// File: flist.f
cpu86Pkg.sv
regFile.sv
aluUnit.sv
instrSequencer.sv
cpu86Top.sv
seqProps_chk.sv
cpu86Tb.sv

// File: Makefile
# Verilator build and run for the cpu86 testbench

TOP = cpu86Tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log
